// ==== hw/ing_adapt_cfg.svh ====
/* Ingress adapter configuration */

`ifndef ING_ADAPT_CFG_SVH
`define ING_ADAPT_CFG_SVH

// Number of physical ingress ports
`define ING_NUM_PORTS   2

// Beat and bus widths in bytes
`define ING_PHYS_BYTES  2
`define ING_BUS_BYTES   8

// Per-port buffer depth in bus words, power of two
`define ING_BUF_DEPTH   16

// Downstream credits after reset
`define ING_CREDITS     4

`define ING_CNT_WIDTH   32

`endif

// ==== hw/ing_adapt_pkg.sv ====
/* Ingress adapter types */

`include "ing_adapt_cfg.svh"

package ing_adapt_pkg;

    // Physical beat and converged bus words
    typedef logic [`ING_PHYS_BYTES*8-1:0] phys_data_t;
    typedef logic [`ING_PHYS_BYTES-1:0]   phys_keep_t;
    typedef logic [`ING_BUS_BYTES*8-1:0]  bus_data_t;
    typedef logic [`ING_BUS_BYTES-1:0]    bus_keep_t;

    // Buffer pointer carries one wrap bit above the address
    typedef logic [$clog2(`ING_BUF_DEPTH):0] buf_ptr_t;
    typedef logic [$clog2(`ING_CREDITS):0]   credit_t;
    typedef logic [`ING_CNT_WIDTH-1:0]       cnt_t;

    typedef enum logic [1:0] {GATE_IDLE, GATE_PASS, GATE_DROP} gate_state_t;

endpackage

// ==== hw/ing_width_upconv.sv ====
/* Beat to bus word packer */

`timescale 1ns/1ps
`include "ing_adapt_cfg.svh"

module ing_width_upconv
    import ing_adapt_pkg::*;
(
    input  logic       ing_phys_ports,
    input  logic       reset,
    input  logic       in_valid,
    input  phys_data_t in_data,
    input  phys_keep_t in_keep,
    input  logic       in_last,
    output logic       word_valid,
    output bus_data_t  word_data,
    output bus_keep_t  word_keep,
    output logic       word_last
);

    localparam int BEATS     = `ING_BUS_BYTES / `ING_PHYS_BYTES;
    localparam int BEAT_W    = `ING_PHYS_BYTES * 8;
    localparam int IDX_W     = $clog2(BEATS);

    logic [IDX_W-1:0] beat_idx;
    bus_data_t        acc_data;
    bus_keep_t        acc_keep;
    bus_data_t        merged_data;
    bus_keep_t        merged_keep;
    logic             word_end;

    // Current beat dropped into its slot on top of what is collected so far
    always_comb begin
        merged_data = acc_data;
        merged_keep = acc_keep;
        merged_data[beat_idx*BEAT_W +: BEAT_W] = in_data;
        merged_keep[beat_idx*`ING_PHYS_BYTES +: `ING_PHYS_BYTES] = in_keep;
    end

    assign word_end = in_last || (beat_idx == IDX_W'(BEATS - 1));

    always_ff @(posedge ing_phys_ports) begin
        if (reset) begin
            beat_idx   <= '0;
            acc_keep   <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (in_valid) begin
                if (word_end) begin
                    word_valid <= 1'b1;
                    beat_idx   <= '0;
                    acc_keep   <= '0;
                end else begin
                    beat_idx <= beat_idx + 1'b1;
                    acc_keep <= merged_keep;
                end
            end
        end
    end

    // Word payload, qualified by word_valid
    always_ff @(posedge ing_phys_ports) begin
        if (in_valid) begin
            acc_data <= merged_data;
            if (word_end) begin
                word_data <= merged_data;
                word_keep <= merged_keep;
                word_last <= in_last;
            end
        end
    end

endmodule

// ==== hw/ing_port_gate.sv ====
/* Frame-aware port gate */

`timescale 1ns/1ps

module ing_port_gate
    import ing_adapt_pkg::*;
(
    input  logic      ing_phys_ports,
    input  logic      reset,
    input  logic      enable,
    input  logic      in_valid,
    input  bus_data_t in_data,
    input  bus_keep_t in_keep,
    input  logic      in_last,
    output logic      out_valid,
    output bus_data_t out_data,
    output bus_keep_t out_keep,
    output logic      out_last,
    output logic      connected,
    output logic      frame_gated
);

    gate_state_t state;
    gate_state_t state_next;
    logic        pass;

    // Decision taken on the first word, held until last
    assign pass = (state == GATE_PASS) || ((state == GATE_IDLE) && enable);

    assign out_valid   = in_valid && pass;
    assign out_data    = in_data;
    assign out_keep    = in_keep;
    assign out_last    = in_last;
    assign frame_gated = in_valid && in_last && !pass;
    assign connected   = enable && (state != GATE_DROP);

    always_comb begin
        state_next = state;
        if (in_valid) begin
            if (in_last) begin
                state_next = GATE_IDLE;
            end else if (state == GATE_IDLE) begin
                state_next = enable ? GATE_PASS : GATE_DROP;
            end
        end
    end

    always_ff @(posedge ing_phys_ports) begin
        if (reset) begin
            state <= GATE_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== hw/ing_frame_buf.sv ====
/* Per-port frame buffer */

`timescale 1ns/1ps
`include "ing_adapt_cfg.svh"

module ing_frame_buf
    import ing_adapt_pkg::*;
(
    input  logic      ing_phys_ports,
    input  logic      reset,
    input  logic      wr_valid,
    input  bus_data_t wr_data,
    input  bus_keep_t wr_keep,
    input  logic      wr_last,
    input  logic      rd_pop,
    output logic      rd_valid,
    output bus_data_t rd_data,
    output bus_keep_t rd_keep,
    output logic      rd_last,
    output logic      buf_full_drop
);

    localparam int ADDR_W = $clog2(`ING_BUF_DEPTH);

    bus_data_t mem_data [`ING_BUF_DEPTH];
    bus_keep_t mem_keep [`ING_BUF_DEPTH];
    logic      mem_last [`ING_BUF_DEPTH];

    buf_ptr_t  wr_ptr;
    buf_ptr_t  commit_ptr;
    buf_ptr_t  rd_ptr;
    logic      discard;
    logic      full;
    logic      wr_take;

    ////////////////////////////////////////////////////////////////////////////
    // Write side

    // Uncommitted words also take room
    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign wr_take = wr_valid && !discard && !full;

    // Overflowed frame reported on its last word
    assign buf_full_drop = wr_valid && wr_last && (discard || full);

    always_ff @(posedge ing_phys_ports) begin
        if (reset) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            discard    <= 1'b0;
        end else if (wr_valid) begin
            if (discard) begin
                if (wr_last) begin
                    discard <= 1'b0;
                end
            end else if (full) begin
                // Roll back the partial frame
                wr_ptr  <= commit_ptr;
                discard <= !wr_last;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
                if (wr_last) begin
                    commit_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ing_phys_ports) begin
        if (wr_take) begin
            mem_data[wr_ptr[ADDR_W-1:0]] <= wr_data;
            mem_keep[wr_ptr[ADDR_W-1:0]] <= wr_keep;
            mem_last[wr_ptr[ADDR_W-1:0]] <= wr_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side, committed words only

    assign rd_valid = (rd_ptr != commit_ptr);
    assign rd_data  = mem_data[rd_ptr[ADDR_W-1:0]];
    assign rd_keep  = mem_keep[rd_ptr[ADDR_W-1:0]];
    assign rd_last  = mem_last[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge ing_phys_ports) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_valid && rd_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// ==== hw/ing_credit_tx.sv ====
/* Credit-based output stage */

`timescale 1ns/1ps
`include "ing_adapt_cfg.svh"

module ing_credit_tx
    import ing_adapt_pkg::*;
(
    input  logic      ing_phys_ports,
    input  logic      reset,
    input  logic      credit_return,
    input  logic      rd_valid,
    input  bus_data_t rd_data,
    input  bus_keep_t rd_keep,
    input  logic      rd_last,
    output logic      rd_pop,
    output logic      out_valid,
    output bus_data_t out_data,
    output bus_keep_t out_keep,
    output logic      out_last
);

    credit_t credits;
    logic    take;

    // Output register drains every cycle, so only credits limit the pop
    assign rd_pop = (credits != '0);
    assign take   = rd_pop && rd_valid;

    // Credit is spent at the pop, the word leaves on the next cycle
    always_ff @(posedge ing_phys_ports) begin
        if (reset) begin
            credits   <= credit_t'(`ING_CREDITS);
            out_valid <= 1'b0;
        end else begin
            credits   <= credits - credit_t'(take) + credit_t'(credit_return);
            out_valid <= take;
        end
    end

    always_ff @(posedge ing_phys_ports) begin
        if (take) begin
            out_data <= rd_data;
            out_keep <= rd_keep;
            out_last <= rd_last;
        end
    end

endmodule

// ==== hw/ing_port_counters.sv ====
/* Per-port ingress counters */

`timescale 1ns/1ps
`include "ing_adapt_cfg.svh"

module ing_port_counters
    import ing_adapt_pkg::*;
(
    input  logic      ing_phys_ports,
    input  logic      reset,
    input  logic      clear,
    input  logic      word_valid,
    input  bus_keep_t word_keep,
    input  logic      word_last,
    input  logic      frame_gated,
    input  logic      buf_full_drop,
    output cnt_t      rx_frames,
    output cnt_t      rx_bytes,
    output cnt_t      gated_frames,
    output cnt_t      overflow_frames
);

    // Number of valid bytes in a word
    function automatic cnt_t keep_bytes(input bus_keep_t keep);
        cnt_t n;
        n = '0;
        for (int i = 0; i < `ING_BUS_BYTES; i++) begin
            n = n + cnt_t'(keep[i]);
        end
        return n;
    endfunction

    always_ff @(posedge ing_phys_ports) begin
        if (reset || clear) begin
            rx_frames       <= '0;
            rx_bytes        <= '0;
            gated_frames    <= '0;
            overflow_frames <= '0;
        end else begin
            if (word_valid) begin
                rx_bytes <= rx_bytes + keep_bytes(word_keep);
                if (word_last) begin
                    rx_frames <= rx_frames + 1'b1;
                end
            end
            if (frame_gated) begin
                gated_frames <= gated_frames + 1'b1;
            end
            if (buf_full_drop) begin
                overflow_frames <= overflow_frames + 1'b1;
            end
        end
    end

endmodule

// ==== hw/ing_port_array_adapt.sv ====
/* Ingress port array adapter */

`timescale 1ns/1ps
`include "ing_adapt_cfg.svh"

module ing_port_array_adapt
    import ing_adapt_pkg::*;
(
    input  logic                      ing_phys_ports,
    input  logic                      reset,
    // Physical ingress beats
    input  logic [`ING_NUM_PORTS-1:0] in_valid,
    input  phys_data_t                in_data [`ING_NUM_PORTS-1:0],
    input  phys_keep_t                in_keep [`ING_NUM_PORTS-1:0],
    input  logic [`ING_NUM_PORTS-1:0] in_last,
    // Control
    input  logic [`ING_NUM_PORTS-1:0] ing_phys_ports_enable,
    input  logic [`ING_NUM_PORTS-1:0] ing_cnts_clear,
    input  logic [`ING_NUM_PORTS-1:0] credit_return,
    // Converged bus words
    output logic [`ING_NUM_PORTS-1:0] out_valid,
    output bus_data_t                 out_data [`ING_NUM_PORTS-1:0],
    output bus_keep_t                 out_keep [`ING_NUM_PORTS-1:0],
    output logic [`ING_NUM_PORTS-1:0] out_last,
    // Status
    output logic [`ING_NUM_PORTS-1:0] ing_ports_connected,
    output logic [`ING_NUM_PORTS-1:0] ing_buf_full_drop,
    output cnt_t                      ing_cnts_rx_frames [`ING_NUM_PORTS-1:0],
    output cnt_t                      ing_cnts_rx_bytes  [`ING_NUM_PORTS-1:0],
    output cnt_t                      ing_cnts_gated     [`ING_NUM_PORTS-1:0],
    output cnt_t                      ing_cnts_overflow  [`ING_NUM_PORTS-1:0]
);

    for (genvar p = 0; p < `ING_NUM_PORTS; p++) begin : lane_g

        logic      word_valid, word_last;
        bus_data_t word_data;
        bus_keep_t word_keep;
        logic      gated_valid, gated_last, frame_gated;
        bus_data_t gated_data;
        bus_keep_t gated_keep;
        logic      rd_valid, rd_last, rd_pop;
        bus_data_t rd_data;
        bus_keep_t rd_keep;

        ing_width_upconv upconv (
            .ing_phys_ports, .reset,
            .in_valid (in_valid[p]), .in_data (in_data[p]),
            .in_keep (in_keep[p]), .in_last (in_last[p]),
            .word_valid, .word_data, .word_keep, .word_last
        );

        // Counters watch the stream ahead of the gate
        ing_port_counters counters (
            .ing_phys_ports, .reset, .clear (ing_cnts_clear[p]),
            .word_valid, .word_keep, .word_last, .frame_gated,
            .buf_full_drop (ing_buf_full_drop[p]),
            .rx_frames (ing_cnts_rx_frames[p]), .rx_bytes (ing_cnts_rx_bytes[p]),
            .gated_frames (ing_cnts_gated[p]), .overflow_frames (ing_cnts_overflow[p])
        );

        ing_port_gate gate (
            .ing_phys_ports, .reset, .enable (ing_phys_ports_enable[p]),
            .in_valid (word_valid), .in_data (word_data),
            .in_keep (word_keep), .in_last (word_last),
            .out_valid (gated_valid), .out_data (gated_data),
            .out_keep (gated_keep), .out_last (gated_last),
            .connected (ing_ports_connected[p]), .frame_gated
        );

        ing_frame_buf frame_buf (
            .ing_phys_ports, .reset,
            .wr_valid (gated_valid), .wr_data (gated_data),
            .wr_keep (gated_keep), .wr_last (gated_last),
            .rd_pop, .rd_valid, .rd_data, .rd_keep, .rd_last,
            .buf_full_drop (ing_buf_full_drop[p])
        );

        ing_credit_tx credit_tx (
            .ing_phys_ports, .reset, .credit_return (credit_return[p]),
            .rd_valid, .rd_data, .rd_keep, .rd_last, .rd_pop,
            .out_valid (out_valid[p]), .out_data (out_data[p]),
            .out_keep (out_keep[p]), .out_last (out_last[p])
        );

    end

endmodule

// ==== verification/tb_ing_port_array_adapt.sv ====
/* Ingress port array adapter testbench */

`timescale 1ns/1ps
`include "ing_adapt_cfg.svh"

module tb_ing_port_array_adapt
    import ing_adapt_pkg::*;
();

    localparam int NP          = `ING_NUM_PORTS;
    localparam int CLK_PERIOD  = 4;
    localparam int PIPE_CYCLES = 4;
    localparam int WAIT_LIMIT  = 400;
    // Cycle budget of the packing, credit, gate, overflow, counter and independence tests
    localparam int TEST_CYCLES = 60 + 150 + 150 + 250 + 40 + 500;
    localparam int MARGIN      = 4;
    localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * MARGIN;

    // Expected word is {last, keep, data}
    typedef logic [`ING_BUS_BYTES*9:0] exp_word_t;

    logic                ing_phys_ports;
    logic                reset;
    logic [NP-1:0]       in_valid;
    phys_data_t          in_data [NP-1:0];
    phys_keep_t          in_keep [NP-1:0];
    logic [NP-1:0]       in_last;
    logic [NP-1:0]       enable;
    logic [NP-1:0]       cnts_clear;
    logic [NP-1:0]       credit_return;
    logic [NP-1:0]       out_valid;
    bus_data_t           out_data [NP-1:0];
    bus_keep_t           out_keep [NP-1:0];
    logic [NP-1:0]       out_last;
    logic [NP-1:0]       connected;
    logic [NP-1:0]       buf_full_drop;
    cnt_t                rx_frames [NP-1:0];
    cnt_t                rx_bytes [NP-1:0];
    cnt_t                gated [NP-1:0];
    cnt_t                overflow [NP-1:0];

    integer              seed;
    int                  errors;
    int                  tests_run;
    int                  tests_failed;
    exp_word_t           exp_q0 [$];
    exp_word_t           exp_q1 [$];
    bus_data_t           acc_data [NP];
    bus_keep_t           acc_keep [NP];
    int                  acc_n [NP];
    int                  exp_frames [NP];
    int                  exp_bytes [NP];
    int                  exp_gated [NP];
    int                  exp_overflow [NP];
    int                  rcv_cnt [NP];
    int                  drop_cnt [NP];
    int                  held [NP];
    int                  extra [NP];
    logic [NP-1:0]       auto_credit;
    bus_keep_t           last_keep [NP];
    logic [NP-1:0]       last_flag;

    ing_port_array_adapt dut (
        .ing_phys_ports, .reset,
        .in_valid, .in_data, .in_keep, .in_last,
        .ing_phys_ports_enable (enable), .ing_cnts_clear (cnts_clear),
        .credit_return,
        .out_valid, .out_data, .out_keep, .out_last,
        .ing_ports_connected (connected), .ing_buf_full_drop (buf_full_drop),
        .ing_cnts_rx_frames (rx_frames), .ing_cnts_rx_bytes (rx_bytes),
        .ing_cnts_gated (gated), .ing_cnts_overflow (overflow)
    );

    always #(CLK_PERIOD / 2) ing_phys_ports = ~ing_phys_ports;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking and reference model

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    function automatic bus_data_t keep_mask(input bus_keep_t keep);
        bus_data_t m;
        for (int i = 0; i < `ING_BUS_BYTES; i++) begin
            m[i*8 +: 8] = {8{keep[i]}};
        end
        return m;
    endfunction

    function automatic int exp_size(input int port);
        return (port == 0) ? exp_q0.size() : exp_q1.size();
    endfunction

    function automatic exp_word_t pop_expected(input int port);
        if (port == 0) begin
            return exp_q0.pop_front();
        end
        return exp_q1.pop_front();
    endfunction

    // Bytes fill a word from byte 0 and a word closes when full or at frame end
    task automatic model_byte(input int port, input logic [7:0] b, input bit last,
                              input bit deliver);
        acc_data[port][acc_n[port]*8 +: 8] = b;
        acc_keep[port][acc_n[port]] = 1'b1;
        acc_n[port]++;
        exp_bytes[port]++;
        if (last) begin
            exp_frames[port]++;
        end
        if (acc_n[port] == `ING_BUS_BYTES || last) begin
            if (deliver && port == 0) begin
                exp_q0.push_back({last, acc_keep[port], acc_data[port]});
            end else if (deliver) begin
                exp_q1.push_back({last, acc_keep[port], acc_data[port]});
            end
            acc_data[port] = '0;
            acc_keep[port] = '0;
            acc_n[port]    = 0;
        end
    endtask

    // Compare every word leaving the DUT with the head of its port queue
    always @(posedge ing_phys_ports) begin : monitor
        exp_word_t w;
        if (!reset) begin
            for (int p = 0; p < NP; p++) begin
                if (buf_full_drop[p]) begin
                    drop_cnt[p]++;
                end
                if (out_valid[p]) begin
                    rcv_cnt[p]++;
                    held[p]++;
                    last_keep[p] = out_keep[p];
                    last_flag[p] = out_last[p];
                    if (exp_size(p) == 0) begin
                        $display("Port %0d delivered a word that no frame produced at %0t",
                                 p, $time);
                        errors++;
                    end else begin
                        w = pop_expected(p);
                        check($sformatf("out_data[%0d]", p),
                              out_data[p] & keep_mask(w[71:64]), w[63:0]);
                        check($sformatf("out_keep[%0d]", p), out_keep[p], w[71:64]);
                        check($sformatf("out_last[%0d]", p), out_last[p], w[72]);
                    end
                end
            end
        end
    end

    // Downstream consumer hands back credits for words it has taken
    always @(negedge ing_phys_ports) begin
        for (int p = 0; p < NP; p++) begin
            if (!reset && held[p] > 0 && (auto_credit[p] || extra[p] > 0)) begin
                credit_return[p] = 1'b1;
                held[p]--;
                if (extra[p] > 0) begin
                    extra[p]--;
                end
            end else begin
                credit_return[p] = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic send_frame(input int port, input int len, input bit deliver);
        logic [7:0] b0;
        logic [7:0] b1;
        for (int i = 0; i < len; i += 2) begin
            b0 = $random(seed);
            b1 = (i + 1 < len) ? $random(seed) : 8'h00;
            model_byte(port, b0, i + 1 == len, deliver);
            if (i + 1 < len) begin
                model_byte(port, b1, i + 2 == len, deliver);
            end
            @(negedge ing_phys_ports);
            in_valid[port] = 1'b1;
            in_data[port]  = {b1, b0};
            in_keep[port]  = (i + 1 < len) ? 2'b11 : 2'b01;
            in_last[port]  = (i + 2 >= len);
        end
        @(negedge ing_phys_ports);
        in_valid[port] = 1'b0;
        in_last[port]  = 1'b0;
    endtask

    task automatic send_random_frames(input int port, input int count);
        int len;
        for (int i = 0; i < count; i++) begin
            len = 1 + ($unsigned($random(seed)) % 47);
            send_frame(port, len, 1'b1);
        end
    endtask

    task automatic return_credits(input int port, input int n);
        extra[port] += n;
    endtask

    task automatic flush_pipe();
        repeat (PIPE_CYCLES) @(negedge ing_phys_ports);
    endtask

    task automatic wait_drain(input int port);
        int cycles = 0;
        while (exp_size(port) != 0 && cycles < WAIT_LIMIT) begin
            @(negedge ing_phys_ports);
            cycles++;
        end
        if (exp_size(port) != 0) begin
            $display("Port %0d: %0d expected words never arrived", port, exp_size(port));
            errors++;
            if (port == 0) begin
                exp_q0.delete();
            end else begin
                exp_q1.delete();
            end
        end
    endtask

    task automatic wait_words(input int port, input int target);
        int cycles = 0;
        while (rcv_cnt[port] < target && cycles < WAIT_LIMIT) begin
            @(negedge ing_phys_ports);
            cycles++;
        end
        if (rcv_cnt[port] < target) begin
            $display("Port %0d: only %0d of %0d words arrived", port, rcv_cnt[port], target);
            errors++;
        end
    endtask

    task automatic settle_credits(input int port);
        int cycles = 0;
        while (held[port] > 0 && cycles < WAIT_LIMIT) begin
            @(negedge ing_phys_ports);
            cycles++;
        end
        @(negedge ing_phys_ports);
        if (held[port] > 0) begin
            $display("Port %0d: credits were not returned", port);
            errors++;
        end
    endtask

    task automatic check_counters(input int port);
        check($sformatf("ing_cnts_rx_frames[%0d]", port), rx_frames[port], exp_frames[port]);
        check($sformatf("ing_cnts_rx_bytes[%0d]", port), rx_bytes[port], exp_bytes[port]);
        check($sformatf("ing_cnts_gated[%0d]", port), gated[port], exp_gated[port]);
        check($sformatf("ing_cnts_overflow[%0d]", port), overflow[port], exp_overflow[port]);
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("%-22s ok", name);
        end else begin
            tests_failed++;
            $display("%-22s %0d errors", name, errors - start_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_packing();
        int e = errors;
        int start = rcv_cnt[0];
        send_frame(0, 11, 1'b1);
        wait_drain(0);
        check("words of 11-byte frame", rcv_cnt[0] - start, 2);
        check("out_keep[0] of word two", last_keep[0], 8'h07);
        check("out_last[0] of word two", last_flag[0], 1'b1);
        settle_credits(0);
        end_test("packing", e);
    endtask

    task automatic test_credit_limit();
        int e = errors;
        int start = rcv_cnt[0];
        auto_credit[0] = 1'b0;
        for (int i = 0; i < 6; i++) begin
            send_frame(0, 6, 1'b1);
        end
        wait_words(0, start + `ING_CREDITS);
        // Idle window in which no further word may leave
        repeat (16) @(negedge ing_phys_ports);
        check("words without credit return", rcv_cnt[0] - start, `ING_CREDITS);
        return_credits(0, 2);
        wait_drain(0);
        check("words after two credits", rcv_cnt[0] - start, 6);
        auto_credit[0] = 1'b1;
        settle_credits(0);
        end_test("credit limit", e);
    endtask

    task automatic test_gate();
        int e = errors;
        fork
            send_frame(1, 20, 1'b1);
            begin
                repeat (7) @(negedge ing_phys_ports);
                enable[1] = 1'b0;
            end
        join
        fork
            send_frame(1, 12, 1'b0);
            begin
                repeat (6) @(negedge ing_phys_ports);
                check("ing_ports_connected[1]", connected[1], 1'b0);
            end
        join
        exp_gated[1]++;
        flush_pipe();
        check_counters(1);
        enable[1] = 1'b1;
        @(negedge ing_phys_ports);
        check("ing_ports_connected[1]", connected[1], 1'b1);
        send_frame(1, 10, 1'b1);
        wait_drain(1);
        settle_credits(1);
        end_test("gate", e);
    endtask

    task automatic test_overflow();
        int e = errors;
        int drops = drop_cnt[0];
        int accepted = 0;
        int in_buf;
        bit dropped = 1'b0;
        auto_credit[0] = 1'b0;
        // Two-word frames with the first words leaving on the initial credits
        while (!dropped) begin
            in_buf = (accepted > `ING_CREDITS) ? accepted - `ING_CREDITS : 0;
            if (in_buf + 2 > `ING_BUF_DEPTH) begin
                send_frame(0, 16, 1'b0);
                dropped = 1'b1;
            end else begin
                send_frame(0, 16, 1'b1);
                accepted += 2;
            end
        end
        exp_overflow[0]++;
        flush_pipe();
        check("ing_buf_full_drop[0] pulses", drop_cnt[0] - drops, 1);
        check_counters(0);
        auto_credit[0] = 1'b1;
        wait_drain(0);
        settle_credits(0);
        end_test("overflow", e);
    endtask

    task automatic test_counters_clear();
        int e = errors;
        check_counters(0);
        check_counters(1);
        @(negedge ing_phys_ports);
        cnts_clear[0] = 1'b1;
        @(negedge ing_phys_ports);
        cnts_clear[0] = 1'b0;
        exp_frames[0]   = 0;
        exp_bytes[0]    = 0;
        exp_gated[0]    = 0;
        exp_overflow[0] = 0;
        check_counters(0);
        check_counters(1);
        end_test("counters and clear", e);
    endtask

    task automatic test_port_independence();
        int e = errors;
        fork
            send_random_frames(0, 6);
            send_random_frames(1, 6);
        join
        wait_drain(0);
        wait_drain(1);
        settle_credits(0);
        settle_credits(1);
        check_counters(0);
        check_counters(1);
        end_test("port independence", e);
    endtask

    initial begin
        seed           = 32'h6bc2_6118;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        ing_phys_ports = 1'b0;
        reset          = 1'b1;
        in_valid       = '0;
        in_last        = '0;
        enable         = '1;
        cnts_clear     = '0;
        credit_return  = '0;
        auto_credit    = '1;
        last_flag      = '0;
        for (int p = 0; p < NP; p++) begin
            in_data[p]      = '0;
            in_keep[p]      = '0;
            acc_data[p]     = '0;
            acc_keep[p]     = '0;
            acc_n[p]        = 0;
            exp_frames[p]   = 0;
            exp_bytes[p]    = 0;
            exp_gated[p]    = 0;
            exp_overflow[p] = 0;
            rcv_cnt[p]      = 0;
            drop_cnt[p]     = 0;
            held[p]         = 0;
            extra[p]        = 0;
            last_keep[p]    = '0;
        end
        repeat (3) @(negedge ing_phys_ports);
        reset = 1'b0;
        @(negedge ing_phys_ports);

        test_packing();
        test_credit_limit();
        test_gate();
        test_overflow();
        test_counters_clear();
        test_port_independence();

        $display("Tests run %0d, tests failing %0d, checks failing %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hw
hw/ing_adapt_pkg.sv
hw/ing_width_upconv.sv
hw/ing_port_gate.sv
hw/ing_frame_buf.sv
hw/ing_credit_tx.sv
hw/ing_port_counters.sv
hw/ing_port_array_adapt.sv
verification/tb_ing_port_array_adapt.sv
